// File: hdl/ipgu.sv
`timescale 1ns/100ps
`default_nettype none

module ipgu
    import ipguPkg::*;
(
    input  wire                     clk,
    input  wire                     reset,

    // Host frame load
    input  wire                     csRam1Ext,
    input  wire                     weRam1Ext,
    input  wire [FRAME_ADDR_W-1:0]  addrRam1Ext,
    input  pixelT                   wrDataRam1Ext,

    // Start and status
    input  wire                     initIpgu,
    output logic                    rdyIpgu,

    // Feature unit side
    input  wire                     rdyHeu,
    output logic                    vldIpgu,
    output logic [WIN_BYTES*8-1:0]  winData
);

    ipguCmdE              cmd;
    logic [WIN_IDX_W-1:0] winIndex;
    logic                 done;
    logic                 bufWrite;
    pixelT                bufData;

    //////////////////////////////////////////////////////////////////////
    // Frame and scaled RAMs
    //////////////////////////////////////////////////////////////////////

    ramPortIf #(.ADDR_W(FRAME_ADDR_W))  framePort ();
    ramPortIf #(.ADDR_W(SCALED_ADDR_W)) scaledPort ();

    // 16x16 input frame
    pixelRam #(.ADDR_W(FRAME_ADDR_W)) frameRam (
        .clk (clk),
        .mem (framePort)
    );

    // 8x8 decimated image
    pixelRam #(.ADDR_W(SCALED_ADDR_W)) scaledRam (
        .clk (clk),
        .mem (scaledPort)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode, execute, result
    //////////////////////////////////////////////////////////////////////

    ipguCtrl ctrlUnit (
        .clk      (clk),
        .reset    (reset),
        .initIpgu (initIpgu),
        .rdyIpgu  (rdyIpgu),
        .done     (done),
        .cmd      (cmd),
        .winIndex (winIndex),
        .vldIpgu  (vldIpgu)
    );

    ipguMover mover (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .winIndex      (winIndex),
        .done          (done),
        .csRam1Ext     (csRam1Ext),
        .weRam1Ext     (weRam1Ext),
        .addrRam1Ext   (addrRam1Ext),
        .wrDataRam1Ext (wrDataRam1Ext),
        .bufWrite      (bufWrite),
        .bufData       (bufData),
        .framePort     (framePort),
        .scaledPort    (scaledPort)
    );

    // Sole owner of the rdyHeu handshake
    ipguOutBuffer outBuffer (
        .clk      (clk),
        .reset    (reset),
        .bufWrite (bufWrite),
        .bufData  (bufData),
        .rdyHeu   (rdyHeu),
        .vldIpgu  (vldIpgu),
        .winData  (winData)
    );

endmodule

`default_nettype wire

// File: hdl/ipguCtrl.sv
`timescale 1ns/100ps
`default_nettype none

module ipguCtrl
    import ipguPkg::*;
(
    input  wire                  clk,
    input  wire                  reset,

    // Host start and status
    input  wire                  initIpgu,
    output logic                 rdyIpgu,

    // Execute stage
    input  wire                  done,
    output ipguCmdE              cmd,
    output logic [WIN_IDX_W-1:0] winIndex,

    // Window pending at the output
    input  wire                  vldIpgu
);

    ctrlStateE state;
    logic      lastWin;
    logic      startReq;

    // Fourth window is being handled
    assign lastWin = (winIndex == WIN_IDX_W'(NUM_WINDOWS - 1));

    // Ready when idle, or as soon as the last window has left
    assign rdyIpgu = (state == ST_IDLE) ||
                     ((state == ST_DRAIN) && lastWin && !vldIpgu);

    // Start only counts while ready
    assign startReq = initIpgu && rdyIpgu;

    //////////////////////////////////////////////////////////////////////
    // Command sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            cmd      <= CMD_NONE;
            winIndex <= '0;
        end else begin
            // Commands are single-cycle pulses
            cmd <= CMD_NONE;
            if (startReq) begin
                state    <= ST_SCALE;
                cmd      <= CMD_SCALE;
                winIndex <= '0;
            end else begin
                case (state)
                    ST_IDLE: begin
                        state <= ST_IDLE;
                    end
                    // Decimation running
                    ST_SCALE: begin
                        if (done) begin
                            state <= ST_WINDOW;
                            cmd   <= CMD_WINDOW;
                        end
                    end
                    // Window gather running
                    ST_WINDOW: begin
                        if (done) begin
                            state <= ST_DRAIN;
                        end
                    end
                    // Back-pressure, wait for the consumer
                    ST_DRAIN: begin
                        if (!vldIpgu) begin
                            state <= lastWin ? ST_IDLE : ST_NEXT;
                        end
                    end
                    // Step to the next pair of scaled rows
                    ST_NEXT: begin
                        winIndex <= winIndex + 1'b1;
                        cmd      <= CMD_WINDOW;
                        state    <= ST_WINDOW;
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ipguMover.sv
`timescale 1ns/100ps
`default_nettype none

module ipguMover
    import ipguPkg::*;
(
    input  wire                     clk,
    input  wire                     reset,

    // Decode stage
    input  ipguCmdE                 cmd,
    input  wire [WIN_IDX_W-1:0]     winIndex,
    output logic                    done,

    // Host write port into the frame RAM
    input  wire                     csRam1Ext,
    input  wire                     weRam1Ext,
    input  wire [FRAME_ADDR_W-1:0]  addrRam1Ext,
    input  pixelT                   wrDataRam1Ext,

    // Window buffer
    output logic                    bufWrite,
    output pixelT                   bufData,

    // RAM ports
    ramPortIf.requester             framePort,
    ramPortIf.requester             scaledPort
);

    ipguCmdE                   phase;
    logic                      readActive;
    logic [SCALED_ADDR_W-1:0]  scanCnt;
    logic [SCALED_ADDR_W-1:0]  rdAddrQ;
    logic                      rdPend;
    logic                      lastPend;
    logic                      lastRead;
    logic                      scaleRd;
    logic                      windowRd;
    logic                      scaleWr;
    logic [FRAME_ADDR_W-1:0]   scanFrameAddr;

    // Read issued this cycle, per phase
    assign scaleRd  = readActive && (phase == CMD_SCALE);
    assign windowRd = readActive && (phase == CMD_WINDOW);

    // 64 reads for scale, 16 for a window
    assign lastRead = (phase == CMD_SCALE) ? (scanCnt == '1)
                                           : (scanCnt[WIN_CNT_W-1:0] == '1);

    //////////////////////////////////////////////////////////////////////
    // Frame RAM, host has priority
    //////////////////////////////////////////////////////////////////////

    // Scan (y, x) maps to frame (2y, 2x)
    assign scanFrameAddr = {scanCnt[SCALED_ADDR_W-1:COL_W], 1'b0,
                            scanCnt[COL_W-1:0], 1'b0};

    assign framePort.cs     = csRam1Ext | scaleRd;
    // Unit never writes the frame
    assign framePort.we     = csRam1Ext & weRam1Ext;
    assign framePort.addr   = csRam1Ext ? addrRam1Ext : scanFrameAddr;
    assign framePort.wrData = wrDataRam1Ext;

    //////////////////////////////////////////////////////////////////////
    // Scaled RAM and buffer feed
    //////////////////////////////////////////////////////////////////////

    // Frame pixel returned, store at its scan address
    assign scaleWr = rdPend && (phase == CMD_SCALE);

    assign scaledPort.cs     = scaleWr | windowRd;
    assign scaledPort.we     = scaleWr;
    // Window rows 2*winIndex and 2*winIndex+1
    assign scaledPort.addr   = scaleWr ? rdAddrQ : {winIndex, scanCnt[WIN_CNT_W-1:0]};
    assign scaledPort.wrData = framePort.rdData;

    assign bufWrite = rdPend && (phase == CMD_WINDOW);
    assign bufData  = scaledPort.rdData;

    // Scan counter and one-stage read valid pipe
    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= CMD_NONE;
            readActive <= 1'b0;
            scanCnt    <= '0;
            rdPend     <= 1'b0;
            lastPend   <= 1'b0;
            done       <= 1'b0;
        end else begin
            rdPend   <= readActive;
            lastPend <= readActive && lastRead;
            // One cycle after the final write
            done     <= lastPend;
            if (cmd != CMD_NONE) begin
                phase      <= cmd;
                readActive <= 1'b1;
                scanCnt    <= '0;
            end else if (readActive) begin
                scanCnt <= scanCnt + 1'b1;
                if (lastRead) begin
                    readActive <= 1'b0;
                end
            end
        end
    end

    // Address of the read in flight
    always_ff @(posedge clk) begin
        rdAddrQ <= scanCnt;
    end

endmodule

`default_nettype wire

// File: hdl/ipguOutBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module ipguOutBuffer
    import ipguPkg::*;
(
    input  wire                       clk,
    input  wire                       reset,

    // Pixels from the execute stage
    input  wire                       bufWrite,
    input  pixelT                     bufData,

    // Window handshake
    input  wire                       rdyHeu,
    output logic                      vldIpgu,
    output logic [WIN_BYTES*8-1:0]    winData
);

    // Byte k is window pixel k
    pixelT [WIN_BYTES-1:0] winReg;
    logic  [WIN_CNT_W-1:0] wrCnt;

    // Shift toward byte 0, first pixel ends up lowest
    always_ff @(posedge clk) begin
        if (bufWrite) begin
            winReg <= {bufData, winReg[WIN_BYTES-1:1]};
        end
    end

    // Fill count and valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            wrCnt   <= '0;
            vldIpgu <= 1'b0;
        end else begin
            if (bufWrite) begin
                // Wraps back to zero after the sixteenth pixel
                wrCnt <= wrCnt + 1'b1;
            end
            if (bufWrite && (wrCnt == '1)) begin
                vldIpgu <= 1'b1;
            end else if (vldIpgu && rdyHeu) begin
                // Window taken
                vldIpgu <= 1'b0;
            end
        end
    end

    assign winData = winReg;

endmodule

`default_nettype wire

// File: hdl/ipguPkg.sv
`default_nettype none

package ipguPkg;

    //////////////////////////////////////////////////////////////////////
    // Image dimensions
    //////////////////////////////////////////////////////////////////////

    // Full frame side in pixels
    localparam int FRAME_DIM = 16;
    // Decimated side, every other row and column
    localparam int SCALED_DIM = FRAME_DIM / 2;

    // Frame address is row then column
    localparam int FRAME_ADDR_W = 2 * $clog2(FRAME_DIM);
    localparam int SCALED_ADDR_W = 2 * $clog2(SCALED_DIM);
    // Column field width in a scaled address
    localparam int COL_W = $clog2(SCALED_DIM);

    //////////////////////////////////////////////////////////////////////
    // Window geometry
    //////////////////////////////////////////////////////////////////////

    // Two scaled rows per window
    localparam int WIN_ROWS = 2;
    localparam int WIN_BYTES = WIN_ROWS * SCALED_DIM;
    localparam int NUM_WINDOWS = SCALED_DIM / WIN_ROWS;
    // Pixel counter inside one window
    localparam int WIN_CNT_W = $clog2(WIN_BYTES);
    localparam int WIN_IDX_W = $clog2(NUM_WINDOWS);

    // One grey pixel
    typedef logic [7:0] pixelT;

    // Decode to execute command
    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_SCALE,
        CMD_WINDOW
    } ipguCmdE;

    // Controller sequence
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCALE,
        ST_WINDOW,
        ST_DRAIN,
        ST_NEXT
    } ctrlStateE;

endpackage

`default_nettype wire

// File: hdl/pixelRam.sv
`timescale 1ns/100ps
`default_nettype none

module pixelRam
    import ipguPkg::*;
#(
    // Depth is 2**ADDR_W pixels
    parameter int ADDR_W = 8
) (
    input  wire           clk,
    ramPortIf.memory      mem
);

    // Pixel storage, no reset on contents
    pixelT memArr [0:(2**ADDR_W)-1];
    pixelT rdQ;

    // Synchronous write and registered read
    always_ff @(posedge clk) begin
        if (mem.cs) begin
            if (mem.we) begin
                memArr[mem.addr] <= mem.wrData;
            end
            // Read returns the old value on a write cycle
            rdQ <= memArr[mem.addr];
        end
    end

    assign mem.rdData = rdQ;

endmodule

`default_nettype wire

// File: hdl/ramPortIf.sv
`timescale 1ns/100ps
`default_nettype none

// One single-port pixel RAM connection
interface ramPortIf
    import ipguPkg::*;
#(
    // Frame RAM uses 8, scaled RAM uses 6
    parameter int ADDR_W = 8
);

    // Chip select, needed for reads and writes
    logic              cs;
    // Write enable, only honoured with cs
    logic              we;
    logic [ADDR_W-1:0] addr;
    pixelT             wrData;
    // Registered read data, one cycle after addr
    pixelT             rdData;

    // Side that issues the accesses
    modport requester (
        output cs,
        output we,
        output addr,
        output wrData,
        input  rdData
    );

    // Side that holds the storage
    modport memory (
        input  cs,
        input  we,
        input  addr,
        input  wrData,
        output rdData
    );

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the IPGU testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project root"
    exit 1
fi

verilator --binary --timing -Wno-fatal --top-module ipguTb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VipguTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

echo "Simulation ended with status 0"
exit 0

// File: sim.f
hdl/ipguPkg.sv
hdl/ramPortIf.sv
hdl/pixelRam.sv
hdl/ipguCtrl.sv
hdl/ipguMover.sv
hdl/ipguOutBuffer.sv
hdl/ipgu.sv
verification/ipguClockGen.sv
verification/ipguTb.sv

// File: verification/ipguClockGen.sv
`timescale 1ns/100ps
`default_nettype none

module ipguClockGen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held for a fixed number of edges, released off the edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/ipguPatterns.hex
// Lines 1-16: frame rows 0-15, 16 pixels each, column 0 first
// Lines 17-20: expected windows 0-3, byte 0 first
3C 3D 3E 3F 38 39 3A 3B 34 35 36 37 30 31 32 33
2C 2D 2E 2F 28 29 2A 2B 24 25 26 27 20 21 22 23
1C 1D 1E 1F 18 19 1A 1B 14 15 16 17 10 11 12 13
0C 0D 0E 0F 08 09 0A 0B 04 05 06 07 00 01 02 03
7C 7D 7E 7F 78 79 7A 7B 74 75 76 77 70 71 72 73
6C 6D 6E 6F 68 69 6A 6B 64 65 66 67 60 61 62 63
5C 5D 5E 5F 58 59 5A 5B 54 55 56 57 50 51 52 53
4C 4D 4E 4F 48 49 4A 4B 44 45 46 47 40 41 42 43
BC BD BE BF B8 B9 BA BB B4 B5 B6 B7 B0 B1 B2 B3
AC AD AE AF A8 A9 AA AB A4 A5 A6 A7 A0 A1 A2 A3
9C 9D 9E 9F 98 99 9A 9B 94 95 96 97 90 91 92 93
8C 8D 8E 8F 88 89 8A 8B 84 85 86 87 80 81 82 83
FC FD FE FF F8 F9 FA FB F4 F5 F6 F7 F0 F1 F2 F3
EC ED EE EF E8 E9 EA EB E4 E5 E6 E7 E0 E1 E2 E3
DC DD DE DF D8 D9 DA DB D4 D5 D6 D7 D0 D1 D2 D3
CC CD CE CF C8 C9 CA CB C4 C5 C6 C7 C0 C1 C2 C3
3C 3E 38 3A 34 36 30 32 1C 1E 18 1A 14 16 10 12
7C 7E 78 7A 74 76 70 72 5C 5E 58 5A 54 56 50 52
BC BE B8 BA B4 B6 B0 B2 9C 9E 98 9A 94 96 90 92
FC FE F8 FA F4 F6 F0 F2 DC DE D8 DA D4 D6 D0 D2

// File: verification/ipguTb.sv
`timescale 1ns/100ps
`default_nettype none

module ipguTb
    import ipguPkg::*;
();

    localparam int CLK_PERIOD = 8;
    // Longest random hold of rdyHeu per window
    localparam int MAX_STALL  = 20;
    localparam int RUNS       = 3;
    // Scale phase plus four windows per run, four times margin
    localparam int WATCHDOG_CYCLES =
        RUNS * (SCALED_DIM * SCALED_DIM + NUM_WINDOWS * (WIN_BYTES + MAX_STALL)) * 4;
    // Frame pixels first, then the expected window bytes
    localparam int EXP_BASE  = FRAME_DIM * FRAME_DIM;
    localparam int PAT_WORDS = EXP_BASE + NUM_WINDOWS * WIN_BYTES;

    wire                    clk;
    wire                    reset;
    logic                   csRam1Ext;
    logic                   weRam1Ext;
    logic [FRAME_ADDR_W-1:0] addrRam1Ext;
    pixelT                  wrDataRam1Ext;
    logic                   initIpgu;
    logic                   rdyHeu;
    wire                    rdyIpgu;
    wire                    vldIpgu;
    wire [WIN_BYTES*8-1:0]  winData;

    pixelT patMem [0:PAT_WORDS-1];

    ipguClockGen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) clockGen (
        .clk   (clk),
        .reset (reset)
    );

    ipgu i_ipgu (
        .clk           (clk),
        .reset         (reset),
        .csRam1Ext     (csRam1Ext),
        .weRam1Ext     (weRam1Ext),
        .addrRam1Ext   (addrRam1Ext),
        .wrDataRam1Ext (wrDataRam1Ext),
        .initIpgu      (initIpgu),
        .rdyIpgu       (rdyIpgu),
        .rdyHeu        (rdyHeu),
        .vldIpgu       (vldIpgu),
        .winData       (winData)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic waitDriveSlot();
        @(posedge clk);
        #1;
    endtask

    // Window byte k of window w, from the file, optionally inverted
    function automatic pixelT expectedByte(input int w, input int k, input logic invert);
        pixelT v;
        v = patMem[EXP_BASE + w * WIN_BYTES + k];
        return invert ? 8'hFF - v : v;
    endfunction

    task automatic loadFrame(input logic invert);
        int a;
        for (a = 0; a < FRAME_DIM * FRAME_DIM; a++) begin
            waitDriveSlot();
            csRam1Ext     = 1'b1;
            weRam1Ext     = 1'b1;
            addrRam1Ext   = FRAME_ADDR_W'(a);
            wrDataRam1Ext = invert ? 8'hFF - patMem[a] : patMem[a];
        end
        waitDriveSlot();
        csRam1Ext = 1'b0;
        weRam1Ext = 1'b0;
    endtask

    // One-cycle start strobe, busy from the next cycle on
    task automatic startUnit();
        waitDriveSlot();
        initIpgu = 1'b1;
        waitDriveSlot();
        initIpgu = 1'b0;
        @(negedge clk);
        checkValue("rdyIpgu", rdyIpgu, 1'b0);
    endtask

    task automatic receiveWindow(input int w, input logic invert, input logic extraStart);
        logic [WIN_BYTES*8-1:0] held;
        int                     stall;
        int                     k;
        // Unit stays busy until the window shows up
        @(negedge clk);
        while (!vldIpgu) begin
            checkValue("rdyIpgu", rdyIpgu, 1'b0);
            @(negedge clk);
        end
        // Still busy while the window waits
        checkValue("rdyIpgu", rdyIpgu, 1'b0);
        held = winData;
        for (k = 0; k < WIN_BYTES; k++) begin
            checkValue($sformatf("winData byte %0d of window %0d", k, w),
                       held[k*8 +: 8], expectedByte(w, k, invert));
        end
        // Back-pressure, window must hold
        stall = int'($urandom_range(MAX_STALL, 0));
        repeat (stall) begin
            @(negedge clk);
            checkValue("vldIpgu", vldIpgu, 1'b1);
            checkValue("winData", winData, held);
            checkValue("rdyIpgu", rdyIpgu, 1'b0);
        end
        waitDriveSlot();
        rdyHeu = 1'b1;
        // Stray start while busy, must be ignored
        if (extraStart) begin
            initIpgu = 1'b1;
        end
        waitDriveSlot();
        rdyHeu   = 1'b0;
        initIpgu = 1'b0;
        // Exactly one window per handshake
        @(negedge clk);
        checkValue("vldIpgu", vldIpgu, 1'b0);
        checkValue("rdyIpgu", rdyIpgu, (w == NUM_WINDOWS - 1));
    endtask

    task automatic runFrame(input logic invert, input logic extraStart);
        int w;
        loadFrame(invert);
        startUnit();
        for (w = 0; w < NUM_WINDOWS; w++) begin
            receiveWindow(w, invert, extraStart && (w == 1));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        csRam1Ext     = 1'b0;
        weRam1Ext     = 1'b0;
        addrRam1Ext   = '0;
        wrDataRam1Ext = '0;
        initIpgu      = 1'b0;
        rdyHeu        = 1'b0;
        void'($urandom(28194));
        $readmemh("verification/ipguPatterns.hex", patMem);
        @(negedge reset);
        @(negedge clk);
        // Idle state after reset
        checkValue("rdyIpgu", rdyIpgu, 1'b1);
        checkValue("vldIpgu", vldIpgu, 1'b0);
        runFrame(1'b0, 1'b0);
        // same frame, stray start during window 1
        runFrame(1'b0, 1'b1);
        // Inverted frame gives inverted windows
        runFrame(1'b1, 1'b0);
        $display("Everything OK");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
